// ==== commit_stim.txt ====
# disp: itype special rd csr_sel pc pred tag; wb: tag value dest taken; wbr: tag dest taken
# commit: tag branch mispredict target redirect redirect_pc; commits: first_tag count
test in_order
disp 2 0 01 000 00000010 0 0
disp 2 0 02 000 00000014 0 1
disp 2 0 00 000 00000018 0 2
disp 2 0 03 000 0000001c 0 3
wbr 3 0 0
wbr 2 0 0
wbr 1 0 0
wbr 0 0 0
commits 0 4
regr 01 0
regr 02 1
reg 00 00000000
regr 03 3
test store_stall
store 0
disp 1 0 00 000 00000020 0 4
disp 2 0 04 000 00000024 0 5
wb 4 0 0 0
wbr 5 0 0
idle 6
store 1
commits 4 2
regr 04 5
test branches
disp 0 0 00 000 00000100 1 6
wb 6 0 00000200 1
commit 6 1 0 00000200 0 0
disp 0 0 00 000 00000140 1 7
disp 2 0 05 000 00000144 0 0
wb 0 0badf00d 0 0
wb 7 0 00000300 0
commit 7 1 1 00000300 1 00000144
reg 05 00000000
disp 0 0 00 000 00000180 0 0
wb 0 0 00000400 1
commit 0 1 1 00000400 1 00000400
test csr_trap
disp 3 0 07 305 00000500 0 0
wb 0 00000800 00000011 0
commit 0 0 0 0 0 0
reg 07 00000011
disp 2 1 00 000 00000600 0 1
wb 1 0 0 0
commit 1 0 0 0 1 00000800
disp 2 2 00 000 00000700 0 0
wb 0 0 0 0
commit 0 0 0 0 1 00000600
test capacity
disp 2 0 00 000 00000900 0 0
disp 2 1 00 000 00000904 0 1
disp 2 0 00 000 00000908 0 2
disp 2 0 00 000 0000090c 0 3
disp 2 0 00 000 00000910 0 4
disp 2 0 00 000 00000914 0 5
disp 2 0 00 000 00000918 0 6
disp 2 0 00 000 0000091c 0 7
ready 0
wb 0 0 0 0
commit 0 0 0 0 0 0
ready 1
test illegal
illegal 1
wb 1 0 0 0
commit 1 0 0 0 1 00000800
illegal 0
disp 2 2 00 000 00000a00 0 0
wb 0 0 0 0
commit 0 0 0 0 1 00000904

// ==== files.f ====
+incdir+.
commit_pkg.sv
rob_head_if.sv
reorder_buffer.sv
commit_unit.sv
csr_block.sv
arch_regfile.sv
commit_top.sv
tb_commit_top.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_commit_top
	./obj_dir/Vtb_commit_top | tee /dev/stderr | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall -f files.f --top-module commit_top

clean:
	rm -rf obj_dir

// ==== tb_commit_top.sv ====
// ----------------------------------------
// Testbench for the retirement top level,
// replaying commands from the stim file
// ----------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module tb_commit_top;
    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  alloc_valid;
    commit_pkg::itype_e    alloc_itype;
    commit_pkg::special_e  alloc_special;
    logic [4:0]            alloc_rd;
    logic [11:0]           alloc_csr_sel;
    logic [`XLEN-1:0]      alloc_pc;
    logic                  alloc_pred;
    logic                  alloc_ready;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    logic                  wb_valid;
    logic [`ROB_TAG_W-1:0] wb_tag;
    logic [`XLEN-1:0]      wb_value;
    logic [`XLEN-1:0]      wb_dest;
    logic                  wb_branch_taken;
    logic                  store_done;
    logic                  illegal_access;
    logic                  commit_valid;
    logic [`ROB_TAG_W-1:0] commit_tag;
    logic                  branch_commit;
    logic                  branch_mispredict;
    logic [`XLEN-1:0]      branch_target;
    logic                  redirect_valid;
    logic [`XLEN-1:0]      redirect_pc;
    logic [4:0]            dbg_rd_addr;
    logic [`XLEN-1:0]      dbg_rd_data;

    integer      seed = 32'he6de_023e;
    int          errors = 0;
    int          test_errors = 0;
    int          n_tests = 0;
    int          fd;
    int          code;
    bit          aborted = 1'b0;
    string       cmd;
    string       test_name = "";
    string       line;
    logic [31:0] f [7];
    logic [31:0] rand_vals [`ROB_DEPTH]; // Random writeback values by tag

    always #5 clk = ~clk;

    commit_top UUT (.*);

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    function automatic int field_count(input string c);
        case (c)
            "disp":                            return 7;
            "wb", "commit":                    return (c == "wb") ? 4 : 6;
            "wbr":                             return 3;
            "commits", "reg", "regr":          return 2;
            "store", "illegal", "idle", "ready": return 1;
            default:                           return 0;
        endcase
    endfunction

    task automatic dispatch_entry();
        int t;
        t = 0;
        @(posedge clk);
        alloc_valid   <= 1'b1;
        alloc_itype   <= commit_pkg::itype_e'(f[0][1:0]);
        alloc_special <= commit_pkg::special_e'(f[1][1:0]);
        alloc_rd      <= f[2][4:0];
        alloc_csr_sel <= f[3][11:0];
        alloc_pc      <= f[4];
        alloc_pred    <= f[5][0];
        @(negedge clk);
        while (!alloc_ready && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (!alloc_ready) begin
            report_timeout("alloc_ready");
        end else begin
            check_value("alloc_tag", f[6], 32'(alloc_tag));
        end
        @(posedge clk);
        alloc_valid <= 1'b0; // Accepted at this edge
    endtask

    task automatic write_back(input logic [31:0] tag, input logic [31:0] value,
                              input logic [31:0] dest, input logic [31:0] taken);
        @(posedge clk);
        wb_valid        <= 1'b1;
        wb_tag          <= tag[`ROB_TAG_W-1:0];
        wb_value        <= value;
        wb_dest         <= dest;
        wb_branch_taken <= taken[0];
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic wait_commit();
        int t;
        t = 0;
        @(negedge clk);
        while (!commit_valid && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (!commit_valid)
            report_timeout("commit_valid");
    endtask

    task automatic close_test();
        if (test_name != "") begin
            n_tests++;
            if (errors == test_errors)
                $display("Test %s: passed", test_name);
            else
                $display("Test %s: failed with %0d errors", test_name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        arst_n = 1'b0;
        alloc_valid = 1'b0;
        alloc_itype = commit_pkg::ITYPE_REG;
        alloc_special = commit_pkg::SPECIAL_NONE;
        alloc_rd = '0;
        alloc_csr_sel = '0;
        alloc_pc = '0;
        alloc_pred = 1'b0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_value = '0;
        wb_dest = '0;
        wb_branch_taken = 1'b0;
        store_done = 1'b0;
        illegal_access = 1'b0;
        dbg_rd_addr = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("commit_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file commit_stim.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(line, fd); // Skip comment text
            end else if (cmd == "test") begin
                close_test();
                code = $fscanf(fd, "%s", test_name);
            end else begin
                for (int i = 0; i < field_count(cmd); i++)
                    code = $fscanf(fd, "%h", f[i]);
                case (cmd)
                    "disp": dispatch_entry();
                    "wb":   write_back(f[0], f[1], f[2], f[3]);
                    "wbr": begin
                        rand_vals[f[0][`ROB_TAG_W-1:0]] = $random(seed);
                        write_back(f[0], rand_vals[f[0][`ROB_TAG_W-1:0]], f[1], f[2]);
                    end
                    "store":   @(posedge clk) store_done <= f[0][0];
                    "illegal": @(posedge clk) illegal_access <= f[0][0];
                    "idle": begin
                        repeat (f[0]) begin
                            @(negedge clk);
                            check_value("commit_valid", 0, 32'(commit_valid));
                        end
                    end
                    "ready": begin
                        @(negedge clk);
                        check_value("alloc_ready", f[0], 32'(alloc_ready));
                    end
                    "commit": begin
                        wait_commit();
                        check_value("commit_tag", f[0], 32'(commit_tag));
                        check_value("branch_commit", f[1], 32'(branch_commit));
                        check_value("branch_mispredict", f[2], 32'(branch_mispredict));
                        if (f[1][0])
                            check_value("branch_target", f[3], branch_target);
                        check_value("redirect_valid", f[4], 32'(redirect_valid));
                        if (f[4][0])
                            check_value("redirect_pc", f[5], redirect_pc);
                    end
                    "commits": begin
                        for (int i = 0; i < f[1] && !aborted; i++) begin
                            wait_commit();
                            check_value("commit_tag", (f[0] + i) % `ROB_DEPTH, 32'(commit_tag));
                            check_value("redirect_valid", 0, 32'(redirect_valid));
                        end
                    end
                    "reg", "regr": begin
                        @(posedge clk);
                        dbg_rd_addr <= f[0][4:0];
                        @(posedge clk); // A squashed entry would retire by this edge
                        @(negedge clk);
                        if (cmd == "reg")
                            check_value("dbg_rd_data", f[1], dbg_rd_data);
                        else
                            check_value("dbg_rd_data", rand_vals[f[1][2:0]], dbg_rd_data);
                    end
                    default: begin
                        errors++;
                        $display("Unknown command %s in the stimulus file", cmd);
                    end
                endcase
            end
        end
        close_test();
        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== commit_top.sv ====
// --------------------------------------
// Retirement top: buffer, commit, CSRs,
// register file
// --------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module commit_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  alloc_valid,
    input  commit_pkg::itype_e    alloc_itype,
    input  commit_pkg::special_e  alloc_special,
    input  logic [4:0]            alloc_rd,
    input  logic [11:0]           alloc_csr_sel,
    input  logic [`XLEN-1:0]      alloc_pc,
    input  logic                  alloc_pred,
    output logic                  alloc_ready,
    output logic [`ROB_TAG_W-1:0] alloc_tag,
    input  logic                  wb_valid,
    input  logic [`ROB_TAG_W-1:0] wb_tag,
    input  logic [`XLEN-1:0]      wb_value,
    input  logic [`XLEN-1:0]      wb_dest,
    input  logic                  wb_branch_taken,
    input  logic                  store_done,
    input  logic                  illegal_access,
    output logic                  commit_valid,
    output logic [`ROB_TAG_W-1:0] commit_tag,
    output logic                  branch_commit,
    output logic                  branch_mispredict,
    output logic [`XLEN-1:0]      branch_target,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc,
    input  logic [4:0]            dbg_rd_addr,
    output logic [`XLEN-1:0]      dbg_rd_data
);
    logic             reg_write;
    logic [4:0]       rd;
    logic [`XLEN-1:0] write_data;
    logic             csr_write;
    logic [11:0]      csr_sel;
    logic [`XLEN-1:0] csr_data;
    logic             trap_take;
    logic [`XLEN-1:0] trap_cause;
    logic [`XLEN-1:0] trap_pc;
    logic             mret_take;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;

    rob_head_if rob_if (.clk(clk));

    reorder_buffer u_rob (
        .clk(clk), .arst_n(arst_n),
        .alloc_valid(alloc_valid), .alloc_itype(alloc_itype),
        .alloc_special(alloc_special), .alloc_rd(alloc_rd),
        .alloc_csr_sel(alloc_csr_sel), .alloc_pc(alloc_pc), .alloc_pred(alloc_pred),
        .alloc_ready(alloc_ready), .alloc_tag(alloc_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .wb_dest(wb_dest), .wb_branch_taken(wb_branch_taken),
        .rob(rob_if.buffer)
    );

    commit_unit u_commit (
        .rob(rob_if.commit),
        .store_done(store_done), .illegal_access(illegal_access),
        .mtvec(mtvec), .mepc(mepc),
        .reg_write(reg_write), .rd(rd), .write_data(write_data),
        .csr_write(csr_write), .csr_sel(csr_sel), .csr_data(csr_data),
        .trap_take(trap_take), .trap_cause(trap_cause), .trap_pc(trap_pc),
        .mret_take(mret_take),
        .commit_valid(commit_valid), .commit_tag(commit_tag),
        .branch_commit(branch_commit), .branch_mispredict(branch_mispredict),
        .branch_target(branch_target),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    csr_block u_csr (
        .clk(clk), .arst_n(arst_n),
        .csr_write(csr_write), .csr_sel(csr_sel), .csr_data(csr_data),
        .trap_take(trap_take), .trap_cause(trap_cause), .trap_pc(trap_pc),
        .mret_take(mret_take),
        .mtvec(mtvec), .mepc(mepc)
    );

    arch_regfile u_regfile (
        .clk(clk), .arst_n(arst_n),
        .reg_write(reg_write), .rd(rd), .write_data(write_data),
        .dbg_rd_addr(dbg_rd_addr), .dbg_rd_data(dbg_rd_data)
    );

endmodule

// ==== arch_regfile.sv ====
// --------------------------------------
// Architectural register file, x0 fixed
// --------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module arch_regfile (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             reg_write,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] write_data,
    input  logic [4:0]       dbg_rd_addr,
    output logic [`XLEN-1:0] dbg_rd_data
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd != 5'd0) begin
            regs[rd] <= write_data; // x0 never written
        end
    end

    assign dbg_rd_data = regs[dbg_rd_addr];

endmodule

// ==== csr_block.sv ====
// --------------------------------------
// Machine CSRs: mtvec, mepc, mcause,
// mscratch
// --------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module csr_block (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             csr_write,
    input  logic [11:0]      csr_sel,
    input  logic [`XLEN-1:0] csr_data,
    input  logic             trap_take,
    input  logic [`XLEN-1:0] trap_cause,
    input  logic [`XLEN-1:0] trap_pc,
    input  logic             mret_take,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc
);
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mscratch;
    logic             sw_write;

    // Trap or return owns the CSR port in its retire cycle
    assign sw_write = csr_write && !trap_take && !mret_take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (trap_take) begin
            mepc   <= trap_pc;   // Faulting or ecall pc
            mcause <= trap_cause;
        end else if (sw_write) begin
            case (csr_sel)
                `CSR_MTVEC:    mtvec    <= csr_data;
                `CSR_MEPC:     mepc     <= csr_data;
                `CSR_MCAUSE:   mcause   <= csr_data;
                `CSR_MSCRATCH: mscratch <= csr_data;
                default: ; // Unimplemented address, dropped
            endcase
        end
    end

endmodule

// ==== commit_unit.sv ====
// --------------------------------------
// Retirement decision for the head entry
// --------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module commit_unit (
    rob_head_if.commit            rob,
    input  logic                  store_done,     // Store at head finished in memory
    input  logic                  illegal_access,
    input  logic [`XLEN-1:0]      mtvec,
    input  logic [`XLEN-1:0]      mepc,
    output logic                  reg_write,
    output logic [4:0]            rd,
    output logic [`XLEN-1:0]      write_data,
    output logic                  csr_write,
    output logic [11:0]           csr_sel,
    output logic [`XLEN-1:0]      csr_data,
    output logic                  trap_take,
    output logic [`XLEN-1:0]      trap_cause,
    output logic [`XLEN-1:0]      trap_pc,
    output logic                  mret_take,
    output logic                  commit_valid,
    output logic [`ROB_TAG_W-1:0] commit_tag,
    output logic                  branch_commit,
    output logic                  branch_mispredict,
    output logic [`XLEN-1:0]      branch_target,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc
);
    commit_pkg::rob_entry_t h;

    assign h = rob.head;

    always_comb begin
        commit_valid      = 1'b0;
        reg_write         = 1'b0;
        write_data        = '0;
        csr_write         = 1'b0;
        csr_data          = '0;
        trap_take         = 1'b0;
        trap_cause        = '0;
        mret_take         = 1'b0;
        branch_commit     = 1'b0;
        branch_mispredict = 1'b0;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        if (rob.head_valid && h.ready) begin
            commit_valid = 1'b1;
            if (h.itype == commit_pkg::ITYPE_BRANCH) begin
                branch_commit     = 1'b1;
                branch_mispredict = (h.branch_pred != h.branch_result);
                redirect_valid    = branch_mispredict;
                redirect_pc       = h.branch_result ? h.dest : h.pc + `XLEN'(4);
            end else if (h.itype == commit_pkg::ITYPE_STORE) begin
                commit_valid = store_done; // Hold until memory acks
            end else if (illegal_access && h.special != commit_pkg::SPECIAL_NONE) begin
                trap_take      = 1'b1;
                trap_cause     = `CAUSE_ILLEGAL;
                redirect_valid = 1'b1;
                redirect_pc    = mtvec;
            end else if (h.special == commit_pkg::SPECIAL_ECALL) begin
                trap_take      = 1'b1;
                trap_cause     = `CAUSE_ECALL;
                redirect_valid = 1'b1;
                redirect_pc    = mtvec;
            end else if (h.special == commit_pkg::SPECIAL_MRET) begin
                mret_take      = 1'b1;
                redirect_valid = 1'b1;
                redirect_pc    = mepc;
            end else if (h.itype == commit_pkg::ITYPE_CSR) begin
                csr_write  = 1'b1;
                csr_data   = h.value;
                reg_write  = 1'b1;
                write_data = h.dest; // Old CSR value into rd
            end else begin
                reg_write  = 1'b1;
                write_data = h.value;
            end
        end
    end

    assign rob.dequeue   = commit_valid;
    assign rob.flush     = redirect_valid; // Mispredict, trap or return
    assign commit_tag    = commit_valid ? h.tag : '0;
    assign rd            = reg_write ? h.rd : '0;
    assign csr_sel       = csr_write ? h.csr_sel : '0;
    assign trap_pc       = trap_take ? h.pc : '0;
    assign branch_target = branch_commit ? h.dest : '0;

    a_redirect_src: assert property (@(posedge rob.clk)
        redirect_valid |-> (commit_valid || trap_take));

    // Buffer must come back empty after any flush
    a_flush_empties: assert property (@(posedge rob.clk)
        rob.flush |=> !rob.head_valid);

endmodule

// ==== reorder_buffer.sv ====
// --------------------------------------
// Circular in-order reorder buffer
// --------------------------------------
`timescale 1ns/1ps
`include "commit_consts.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   alloc_valid,
    input  commit_pkg::itype_e     alloc_itype,
    input  commit_pkg::special_e   alloc_special,
    input  logic [4:0]             alloc_rd,
    input  logic [11:0]            alloc_csr_sel,
    input  logic [`XLEN-1:0]       alloc_pc,
    input  logic                   alloc_pred,
    output logic                   alloc_ready,
    output logic [`ROB_TAG_W-1:0]  alloc_tag,
    input  logic                   wb_valid,
    input  logic [`ROB_TAG_W-1:0]  wb_tag,
    input  logic [`XLEN-1:0]       wb_value,
    input  logic [`XLEN-1:0]       wb_dest,
    input  logic                   wb_branch_taken,
    rob_head_if.buffer             rob
);
    commit_pkg::rob_entry_t entries [`ROB_DEPTH];

    logic [`ROB_TAG_W-1:0] head_ptr;
    logic [`ROB_TAG_W-1:0] tail_ptr;
    logic [`ROB_TAG_W:0]   count;
    logic                  alloc_fire;
    logic [`ROB_TAG_W-1:0] wb_offset;
    logic                  wb_live;
    logic [`ROB_TAG_W-1:0] tail_offset;
    logic                  tail_live;

    assign alloc_ready = (count != `ROB_DEPTH) && !rob.flush;
    assign alloc_tag   = tail_ptr;
    assign alloc_fire  = alloc_valid && alloc_ready;

    assign rob.head       = entries[head_ptr];
    assign rob.head_valid = (count != '0);

    // Distance from head, wraps with the pointers
    assign wb_offset = wb_tag - head_ptr;
    assign wb_live   = ({1'b0, wb_offset} < count);

    assign tail_offset = tail_ptr - head_ptr;
    assign tail_live   = ({1'b0, tail_offset} < count); // Tail slot still in flight

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (rob.flush) begin // Squash everything in flight
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (alloc_fire)
                tail_ptr <= tail_ptr + 1'b1;
            if (rob.dequeue)
                head_ptr <= head_ptr + 1'b1;
            case ({alloc_fire, rob.dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entries[tail_ptr] <= '{
                itype:         alloc_itype,
                special:       alloc_special,
                ready:         1'b0,
                tag:           tail_ptr,
                rd:            alloc_rd,
                csr_sel:       alloc_csr_sel,
                pc:            alloc_pc,
                value:         '0,
                dest:          '0,
                branch_pred:   alloc_pred,
                branch_result: 1'b0
            };
        end
        if (wb_valid && !rob.flush) begin
            entries[wb_tag].ready         <= 1'b1;
            entries[wb_tag].value         <= wb_value;
            entries[wb_tag].dest          <= wb_dest;
            entries[wb_tag].branch_result <= wb_branch_taken;
        end
    end

    // Allocation never lands on a live entry
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_fire |-> !tail_live);

    a_no_deq_empty: assert property (@(posedge clk) disable iff (!arst_n)
        rob.dequeue |-> (count != '0));

    a_wb_live: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid && !rob.flush) |-> wb_live);

endmodule

// ==== rob_head_if.sv ====
// --------------------------------------
// Head entry and retire strobes between
// the reorder buffer and commit
// --------------------------------------
`timescale 1ns/1ps

interface rob_head_if (
    input logic clk
);
    commit_pkg::rob_entry_t head;
    logic                   head_valid; // Buffer not empty
    logic                   dequeue;
    logic                   flush;

    modport buffer (
        output head,
        output head_valid,
        input  dequeue,
        input  flush
    );

    modport commit (
        input  clk, // Sampling clock for commit checks
        input  head,
        input  head_valid,
        output dequeue,
        output flush
    );
endinterface

// ==== commit_pkg.sv ====
// --------------------------------------
// Instruction class and special-op enums,
// reorder buffer entry layout
// --------------------------------------
`include "commit_consts.svh"

package commit_pkg;

    typedef enum logic [1:0] {
        ITYPE_BRANCH = 2'b00,
        ITYPE_STORE  = 2'b01,
        ITYPE_REG    = 2'b10, // ALU, load, jalr
        ITYPE_CSR    = 2'b11
    } itype_e;

    typedef enum logic [1:0] {
        SPECIAL_NONE  = 2'b00,
        SPECIAL_ECALL = 2'b01,
        SPECIAL_MRET  = 2'b10
    } special_e;

    // One in-flight instruction
    typedef struct packed {
        itype_e                  itype;
        special_e                special;
        logic                    ready;         // Result has been written back
        logic [`ROB_TAG_W-1:0]   tag;
        logic [4:0]              rd;
        logic [11:0]             csr_sel;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        value;         // Result or CSR write data
        logic [`XLEN-1:0]        dest;          // Branch target or old CSR value
        logic                    branch_pred;
        logic                    branch_result; // Actual taken
    } rob_entry_t;

endpackage

// ==== commit_consts.svh ====
// --------------------------------------
// Widths, buffer sizing, machine CSR
// addresses and trap cause codes
// --------------------------------------
`ifndef COMMIT_CONSTS_SVH
`define COMMIT_CONSTS_SVH

`define XLEN          32
`define ROB_DEPTH     8
`define ROB_TAG_W     3

`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MSCRATCH  12'h340

`define CAUSE_ECALL   32'd11 // ecall from M-mode
`define CAUSE_ILLEGAL 32'd5  // load access fault
`endif
